//--- verilog.f
design/aib_red_pkg.sv
design/aib_repair_ctrl.sv
design/aib_shift_array.sv
design/aib_red_column.sv
test/aib_red_checker.sv
test/tb_aib_red_column.sv

//--- Bender.yml
package:
  name: aib_red_column

dependencies: {}

sources:
  # design, package first
  - files:
      - design/aib_red_pkg.sv
      - design/aib_repair_ctrl.sv
      - design/aib_shift_array.sv
      - design/aib_red_column.sv

  # testbench
  - target: test
    files:
      - test/aib_red_checker.sv
      - test/tb_aib_red_column.sv

//--- test/tb_aib_red_column.sv
/* single build with NUM_LANES = 8 and xorshift seed 66; inputs change on the falling edge
   all comparing happens in the checker instance */
`timescale 1ns/1ps
`default_nettype none

module tb_aib_red_column
  import aib_red_pkg::*;
#(
  parameter int unsigned NUM_LANES = 8
);

  localparam int unsigned PAD_W          = $clog2(NUM_LANES + 1);
  localparam int unsigned ILLEGAL_CODES  = (1 << PAD_W) - NUM_LANES - 1;
  localparam int unsigned CLK_PERIOD_NS  = 10;
  localparam int unsigned RESET_CYCLES   = 16;
  localparam int unsigned SETTLE_CYCLES  = 8;
  localparam int unsigned HOLD_CYCLES    = 4;
  localparam int unsigned RANDOM_FAULTS  = 20;
  localparam int unsigned REJECT_CYCLES  = 6 * (HOLD_CYCLES + 1);
  localparam int unsigned MIXED_CYCLES   = 200;
  localparam int unsigned PLANNED_CYCLES = RESET_CYCLES + SETTLE_CYCLES
                                         + (NUM_LANES + 1 + RANDOM_FAULTS) * (HOLD_CYCLES + 1)
                                         + REJECT_CYCLES + MIXED_CYCLES
                                         + (HOLD_CYCLES + 1) + 2;
  localparam int unsigned WATCHDOG_NS    = 2 * PLANNED_CYCLES * CLK_PERIOD_NS + 500;

  logic             clk;
  logic             rst_n;
  logic             cfg_wr;
  logic             cfg_repair_en;
  logic [PAD_W-1:0] cfg_fault_pad;
  tx_lane_t         core_tx [NUM_LANES];
  rx_lane_t         core_rx [NUM_LANES];
  tx_lane_t         pad_tx [NUM_LANES + 1];
  rx_lane_t         pad_rx [NUM_LANES + 1];
  logic             cfg_err;
  logic             repair_active;
  int               check_count;
  int               tx_errors;
  int               rx_errors;
  int               status_errors;
  logic [31:0]      rng_state;

  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  aib_red_column #(
    .NUM_LANES (NUM_LANES)
  ) i_aib_red_column (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_wr        (cfg_wr),
    .cfg_repair_en (cfg_repair_en),
    .cfg_fault_pad (cfg_fault_pad),
    .core_tx       (core_tx),
    .core_rx       (core_rx),
    .pad_tx        (pad_tx),
    .pad_rx        (pad_rx),
    .cfg_err       (cfg_err),
    .repair_active (repair_active)
  );

  aib_red_checker #(
    .NUM_LANES (NUM_LANES)
  ) i_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_wr        (cfg_wr),
    .cfg_repair_en (cfg_repair_en),
    .cfg_fault_pad (cfg_fault_pad),
    .core_tx       (core_tx),
    .core_rx       (core_rx),
    .pad_tx        (pad_tx),
    .pad_rx        (pad_rx),
    .cfg_err       (cfg_err),
    .repair_active (repair_active),
    .check_count   (check_count),
    .tx_errors     (tx_errors),
    .rx_errors     (rx_errors),
    .status_errors (status_errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // fresh bundles on every lane and pad
  task automatic randomize_data();
    for (int l = 0; l < NUM_LANES; l++) begin
      rng_state  = xorshift32(rng_state);
      core_tx[l] = tx_lane_t'(rng_state[8:0]);
    end
    for (int p = 0; p <= NUM_LANES; p++) begin
      rng_state = xorshift32(rng_state);
      pad_rx[p] = rx_lane_t'(rng_state[2:0]);
    end
  endtask

  task automatic drive_cycle(input logic wr, input logic en, input logic [PAD_W-1:0] fault);
    @(negedge clk);
    cfg_wr        = wr;
    cfg_repair_en = en;
    cfg_fault_pad = fault;
    randomize_data();
  endtask

  // one write, then data moving under the resulting map
  task automatic repair_and_hold(input logic en, input logic [PAD_W-1:0] fault);
    drive_cycle(1'b1, en, fault);
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      drive_cycle(1'b0, en, fault);
    end
  endtask

  task automatic run_rejection();
    logic [PAD_W-1:0] bad_pad;
    if (ILLEGAL_CODES == 0) begin
      $display("no out-of-range fault index exists for %0d lanes, rejection skipped",
               NUM_LANES);
    end else begin
      repair_and_hold(1'b1, PAD_W'(2));
      for (int i = 0; i < 2; i++) begin
        rng_state = xorshift32(rng_state);
        bad_pad   = PAD_W'(NUM_LANES + 1 + rng_state % ILLEGAL_CODES);
        repair_and_hold(1'b1, bad_pad);
      end
      // any index is accepted while repair is off
      repair_and_hold(1'b0, {PAD_W{1'b1}});
      repair_and_hold(1'b1, bad_pad);
      repair_and_hold(1'b1, PAD_W'(NUM_LANES - 1));
    end
  endtask

  // writes land on random cycles, legal or not
  task automatic run_mixed_updates();
    logic             wr;
    logic             en;
    logic [PAD_W-1:0] fault;
    for (int i = 0; i < MIXED_CYCLES; i++) begin
      rng_state = xorshift32(rng_state);
      wr        = rng_state[0];
      en        = (rng_state[9:8] != 2'b00);
      fault     = rng_state[16 +: PAD_W];
      drive_cycle(wr, en, fault);
    end
  endtask

  initial begin
    int total_errors;
    rng_state     = 32'd66;
    clk           = 1'b0;
    rst_n         = 1'b0;
    cfg_wr        = 1'b0;
    cfg_repair_en = 1'b0;
    cfg_fault_pad = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      core_tx[l] = '0;
    end
    for (int p = 0; p <= NUM_LANES; p++) begin
      pad_rx[p] = '0;
    end

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // one-to-one map straight after reset
    repeat (SETTLE_CYCLES) drive_cycle(1'b0, 1'b0, '0);

    // every pad as the fault, spare included
    for (int p = 0; p <= NUM_LANES; p++) begin
      repair_and_hold(1'b1, PAD_W'(p));
    end
    for (int i = 0; i < RANDOM_FAULTS; i++) begin
      rng_state = xorshift32(rng_state);
      repair_and_hold(1'b1, PAD_W'(rng_state % (NUM_LANES + 1)));
    end

    run_rejection();
    run_mixed_updates();

    // repair off again
    repair_and_hold(1'b0, '0);
    drive_cycle(1'b0, 1'b0, '0);
    @(negedge clk);

    total_errors = tx_errors + rx_errors + status_errors;
    $display("checks %0d, errors pad_tx %0d, core_rx %0d, status %0d",
             check_count, tx_errors, rx_errors, status_errors);
    if (check_count > 0 && total_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      if (check_count == 0) begin
        $display("the checker made no comparisons");
      end
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the stimulus did not complete", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule : tb_aib_red_column

`default_nettype wire

//--- test/aib_red_checker.sv
/* compares at each rising edge, before that edge's register updates are visible
   keeps its own repair setting and applies the legality rule to every sampled cfg_wr */
`timescale 1ns/1ps
`default_nettype none

module aib_red_checker
  import aib_red_pkg::*;
#(
  parameter int unsigned NUM_LANES = 8
) (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             cfg_wr,
  input  wire logic                             cfg_repair_en,
  input  wire logic [$clog2(NUM_LANES + 1)-1:0] cfg_fault_pad,
  input  wire tx_lane_t                         core_tx [NUM_LANES],
  input  wire rx_lane_t                         core_rx [NUM_LANES],
  input  wire tx_lane_t                         pad_tx [NUM_LANES + 1],
  input  wire rx_lane_t                         pad_rx [NUM_LANES + 1],
  input  wire logic                             cfg_err,
  input  wire logic                             repair_active,
  output int                                    check_count,
  output int                                    tx_errors,
  output int                                    rx_errors,
  output int                                    status_errors
);

  localparam int unsigned PAD_W = $clog2(NUM_LANES + 1);

  // model of the stored repair setting
  logic             model_en;
  logic [PAD_W-1:0] model_fault;
  logic             model_err;

  initial begin
    model_en      = 1'b0;
    model_fault   = '0;
    model_err     = 1'b0;
    check_count   = 0;
    tx_errors     = 0;
    rx_errors     = 0;
    status_errors = 0;
  end

  // lane expected on pad p, -1 when the pad should be idle
  function automatic int tx_source(input int p, input logic en, input int fault);
    if (en && p == fault) begin
      return -1;
    end
    if (en && p > fault) begin
      return p - 1;
    end
    if (p < NUM_LANES) begin
      return p;
    end
    return -1;
  endfunction

  // pad that lane l should return
  function automatic int rx_source(input int l, input logic en, input int fault);
    if (en && l >= fault) begin
      return l + 1;
    end
    return l;
  endfunction

  task automatic compare_outputs();
    int       src;
    tx_lane_t exp_tx;
    rx_lane_t exp_rx;
    for (int p = 0; p <= NUM_LANES; p++) begin
      src = tx_source(p, model_en, int'(model_fault));
      if (src < 0) begin
        exp_tx = '0;
      end else begin
        exp_tx = core_tx[src];
      end
      check_count++;
      if (pad_tx[p] !== exp_tx) begin
        tx_errors++;
        $display("CHECK FAILED @%0t: pad_tx[%0d] = %h, expected %h (repair %0b, fault %0d)",
                 $time, p, pad_tx[p], exp_tx, model_en, model_fault);
      end
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      src    = rx_source(l, model_en, int'(model_fault));
      exp_rx = pad_rx[src];
      check_count++;
      if (core_rx[l] !== exp_rx) begin
        rx_errors++;
        $display("CHECK FAILED @%0t: core_rx[%0d] = %h, expected %h from pad %0d",
                 $time, l, core_rx[l], exp_rx, src);
      end
    end
    check_count += 2;
    if (cfg_err !== model_err) begin
      status_errors++;
      $display("CHECK FAILED @%0t: cfg_err = %b, expected %b", $time, cfg_err, model_err);
    end
    if (repair_active !== model_en) begin
      status_errors++;
      $display("CHECK FAILED @%0t: repair_active = %b, expected %b",
               $time, repair_active, model_en);
    end
  endtask

  // a write is kept only if the index is in range or repair is off
  task automatic apply_write();
    logic legal;
    legal = !cfg_repair_en || (cfg_fault_pad <= NUM_LANES);
    if (legal) begin
      model_en    = cfg_repair_en;
      model_fault = cfg_fault_pad;
      model_err   = 1'b0;
    end else begin
      model_err = 1'b1;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      model_en    = 1'b0;
      model_fault = '0;
      model_err   = 1'b0;
    end else begin
      // outputs still show the setting from before this edge
      compare_outputs();
      if (cfg_wr) begin
        apply_write();
      end
    end
  end

endmodule : aib_red_checker

`default_nettype wire

//--- design/aib_red_column.sv
/* NUM_LANES must be 2 or more; pad NUM_LANES is the spare
   steering follows a legal cfg_wr from the edge where it is sampled */
`timescale 1ns/1ps
`default_nettype none

module aib_red_column
  import aib_red_pkg::*;
#(
  parameter int unsigned NUM_LANES = 8
) (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  // repair configuration
  input  wire logic                             cfg_wr,
  input  wire logic                             cfg_repair_en,
  input  wire logic [$clog2(NUM_LANES + 1)-1:0] cfg_fault_pad,
  // core side
  input  wire tx_lane_t                         core_tx [NUM_LANES],
  output rx_lane_t                              core_rx [NUM_LANES],
  // pad side
  output tx_lane_t                              pad_tx [NUM_LANES + 1],
  input  wire rx_lane_t                         pad_rx [NUM_LANES + 1],
  // status
  output logic                                  cfg_err,
  output logic                                  repair_active
);

  // shared by both directions
  logic [NUM_LANES:0] shift_en;

  aib_repair_ctrl #(
    .NUM_LANES (NUM_LANES)
  ) i_repair_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_wr        (cfg_wr),
    .cfg_repair_en (cfg_repair_en),
    .cfg_fault_pad (cfg_fault_pad),
    .shift_en      (shift_en),
    .cfg_err       (cfg_err),
    .repair_active (repair_active)
  );

  // lanes out to pads, unused pad driven idle
  aib_shift_array #(
    .NUM_LANES (NUM_LANES),
    .payload_t (tx_lane_t),
    .DIR       (dir_tx)
  ) i_tx_steer (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_en   (shift_en),
    .src_bundle (core_tx),
    .dst_bundle (pad_tx)
  );

  // pads back to lanes, faulty pad dropped
  aib_shift_array #(
    .NUM_LANES (NUM_LANES),
    .payload_t (rx_lane_t),
    .DIR       (dir_rx)
  ) i_rx_steer (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_en   (shift_en),
    .src_bundle (pad_rx),
    .dst_bundle (core_rx)
  );

endmodule : aib_red_column

`default_nettype wire

//--- design/aib_shift_array.sv
/* purely combinational steering; clk and rst_n only clock the assertion
   shift_en must be a thermometer with bit 0 low, as the repair controller drives it */
`timescale 1ns/1ps
`default_nettype none

module aib_shift_array
  import aib_red_pkg::*;
#(
  parameter int unsigned NUM_LANES = 8,
  parameter type         payload_t = tx_lane_t,
  parameter shift_dir_e  DIR       = dir_tx,
  parameter payload_t    IDLE      = '0
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic [NUM_LANES:0] shift_en,
  // lanes for dir_tx, pads for dir_rx
  input  wire payload_t           src_bundle [(DIR == dir_tx) ? NUM_LANES : NUM_LANES + 1],
  // pads for dir_tx, lanes for dir_rx
  output payload_t                dst_bundle [(DIR == dir_tx) ? NUM_LANES + 1 : NUM_LANES]
);

  // pad that carries no lane, found from the edge of the thermometer
  logic [NUM_LANES:0] pad_unused;

  for (genvar p = 0; p <= NUM_LANES; p++) begin : g_unused
    if (p == NUM_LANES) begin : g_spare
      // spare is left over when nothing shifted onto it
      assign pad_unused[p] = !shift_en[p];
    end else begin : g_inner
      // faulty pad, just below the first shifted one
      assign pad_unused[p] = !shift_en[p] && shift_en[p + 1];
    end
  end

  if (DIR == dir_tx) begin : g_tx
    // each pad picks its own lane or the lane below
    for (genvar p = 0; p <= NUM_LANES; p++) begin : g_pad
      if (p == 0) begin : g_bottom
        assign dst_bundle[p] = pad_unused[p] ? IDLE : src_bundle[p];
      end else if (p == NUM_LANES) begin : g_spare
        // spare only ever takes the top lane
        assign dst_bundle[p] = pad_unused[p] ? IDLE : src_bundle[p - 1];
      end else begin : g_mid
        assign dst_bundle[p] = pad_unused[p] ? IDLE :
                               shift_en[p]   ? src_bundle[p - 1] : src_bundle[p];
      end
    end
  end else begin : g_rx
    // each lane picks its own pad or the pad above
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
      assign dst_bundle[l] = shift_en[l + 1] ? src_bundle[l + 1] : src_bundle[l];
    end
  end

  // exactly one pad is dropped from the mapping in either direction
  a_single_unused_pad : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot(pad_unused)
  ) else $error("steering leaves %0d pads unused", $countones(pad_unused));

endmodule : aib_shift_array

`default_nettype wire

//--- design/aib_repair_ctrl.sv
/* one faulty pad only; an out-of-range index with repair enabled is rejected and flagged
   shift_en is registered and follows a legal write from the edge where it is sampled */
`timescale 1ns/1ps
`default_nettype none

module aib_repair_ctrl #(
  parameter int unsigned NUM_LANES = 8
) (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             cfg_wr,
  input  wire logic                             cfg_repair_en,
  input  wire logic [$clog2(NUM_LANES + 1)-1:0] cfg_fault_pad,
  output logic      [NUM_LANES:0]               shift_en,
  output logic                                  cfg_err,
  output logic                                  repair_active
);

  localparam int unsigned PAD_W = $clog2(NUM_LANES + 1);

  logic             cfg_legal;
  logic             repair_en_q;
  logic             repair_en_d;
  logic [PAD_W-1:0] fault_q;
  logic [PAD_W-1:0] fault_d;
  logic [NUM_LANES:0] shift_d;
  logic [NUM_LANES:0] shift_q;
  logic             cfg_err_q;

  // index NUM_LANES is the spare pad itself
  assign cfg_legal = !cfg_repair_en || (cfg_fault_pad <= NUM_LANES);

  // next setting, old one held on an illegal write
  always_comb begin
    repair_en_d = repair_en_q;
    fault_d     = fault_q;
    if (cfg_wr && cfg_legal) begin
      repair_en_d = cfg_repair_en;
      fault_d     = cfg_fault_pad;
    end
  end

  // thermometer decode, every pad above the fault shifts up
  always_comb begin
    for (int p = 0; p <= NUM_LANES; p++) begin
      shift_d[p] = repair_en_d && (p > fault_d);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      repair_en_q <= 1'b0;
      fault_q     <= '0;
      shift_q     <= '0;
      cfg_err_q   <= 1'b0;
    end else begin
      repair_en_q <= repair_en_d;
      fault_q     <= fault_d;
      shift_q     <= shift_d;
      // error level stays until the next legal write
      if (cfg_wr) begin
        cfg_err_q <= !cfg_legal;
      end
    end
  end

  assign shift_en      = shift_q;
  assign cfg_err       = cfg_err_q;
  assign repair_active = repair_en_q;

  // no low bit may sit above a high bit
  a_shift_thermometer : assert property (
    @(posedge clk) disable iff (!rst_n)
    ((shift_en << 1) & ~shift_en) == '0
  ) else $error("shift_en is not a thermometer pattern");

  // pad 0 has no lane below it to take
  a_pad0_never_shifted : assert property (
    @(posedge clk) disable iff (!rst_n)
    !shift_en[0]
  ) else $error("shift_en set on pad 0");

endmodule : aib_repair_ctrl

`default_nettype wire

//--- design/aib_red_pkg.sv
/* bundle layouts follow the reference pad muxes, with clock, loopback and rx enable omitted
   an all-zero bundle is the idle value for a pad that carries no lane */
`default_nettype none

package aib_red_pkg;

  // transmit bundle, core lane toward pad
  typedef struct packed {
    logic       data0;
    logic       data1;
    logic       dataselb;
    logic       ddr_en;
    logic       tx_en;
    // drive strength codes
    logic [1:0] ndrv;
    logic [1:0] pdrv;
  } tx_lane_t;

  // receive bundle, pad toward core lane
  typedef struct packed {
    logic odat0;
    logic odat1;
    // async path bypasses the rx flops
    logic odat_async;
  } rx_lane_t;

  // steering direction
  // dir_tx maps lanes onto pads, dir_rx maps pads onto lanes
  typedef enum logic {
    dir_tx,
    dir_rx
  } shift_dir_e;

endpackage : aib_red_pkg

`default_nettype wire
